// File: hw/trig_pkg.sv
// shared widths, trigger type codes and FSM states; the sample block is fixed at 40 samples of 12 bits
`default_nettype none

package trig_pkg;

   localparam int unsigned num_samples       = 40;
   localparam int unsigned sample_width      = 12;
   localparam int unsigned ext_trig_delay    = 3;   // back-panel input path latency in writes
   localparam int unsigned lvds_pulse_cycles = 2;

   typedef logic signed [sample_width-1:0]             sample_t;
   typedef logic        [num_samples*sample_width-1:0] sample_block_t;  // sample 0 in the low bits
   typedef logic        [9:0]                          ram_addr_t;
   typedef logic        [15:0]                         length_t;
   typedef logic        [7:0]                          tot_t;
   typedef logic        [7:0]                          merge_t;
   typedef logic        [4:0]                          dsample_t;
   typedef logic        [31:0]                         stamp_t;

   typedef enum logic [7:0] {
      trig_none      = 8'd0,
      trig_rising    = 8'd1,
      trig_falling   = 8'd2,
      trig_lvds      = 8'd3,
      trig_auto      = 8'd4,
      trig_ext       = 8'd5,
      trig_lvds_echo = 8'd30   // lvds trigger that also answers on the other side
   } trig_type_t;

   typedef enum logic [3:0] {
      st_ready     = 4'd0,
      st_prefill   = 4'd1,
      st_armed     = 4'd2,
      st_fire      = 4'd3,
      st_wait_lvds = 4'd4,
      st_force     = 4'd5,
      st_wait_ext  = 4'd6,
      st_post      = 4'd7,
      st_done      = 4'd8
   } acq_state_t;

endpackage

`default_nettype wire

// File: hw/cfg_sync.sv
// single register stage for inputs from other domains; multi-bit values must be held stable while used
`default_nettype none
`timescale 1ns/100ps

module cfg_sync (
   input  logic                  clklvds,
   input  logic                  rst_n,
   input  trig_pkg::sample_t     lower_thresh_in,
   input  trig_pkg::sample_t     upper_thresh_in,
   input  trig_pkg::length_t     length_in,
   input  trig_pkg::length_t     prelength_in,
   input  trig_pkg::trig_type_t  trigger_type_in,
   input  trig_pkg::tot_t        tot_in,
   input  trig_pkg::merge_t      merging_in,
   input  trig_pkg::dsample_t    downsample_in,
   input  logic                  trigger_live_in,
   input  logic                  read_done_in,
   input  logic                  exttrigin,
   input  logic                  lvdsin_trig,
   input  logic                  lvdsin_trig_b,
   output trig_pkg::sample_t     lower_thresh,
   output trig_pkg::sample_t     upper_thresh,
   output trig_pkg::length_t     length,
   output trig_pkg::length_t     prelength,
   output trig_pkg::trig_type_t  trigger_type,
   output trig_pkg::tot_t        tot,
   output trig_pkg::merge_t      merging,
   output trig_pkg::dsample_t    downsample,
   output logic                  trigger_live,
   output logic                  read_done,
   output logic                  ext_high,
   output logic                  ext_rise,
   output logic                  lvds_trig,
   output logic                  lvds_trig_b
);
   import trig_pkg::*;

   logic ext_last;   // ext_high one cycle earlier

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         lower_thresh <= '0;
         upper_thresh <= '0;
         length       <= '0;
         prelength    <= '0;
         trigger_type <= trig_none;
         tot          <= '0;
         merging      <= '0;
         downsample   <= '0;
         trigger_live <= 1'b0;
         read_done    <= 1'b0;
         ext_high     <= 1'b0;
         ext_last     <= 1'b0;
         lvds_trig    <= 1'b0;
         lvds_trig_b  <= 1'b0;
      end else begin
         lower_thresh <= lower_thresh_in;
         upper_thresh <= upper_thresh_in;
         length       <= length_in;
         prelength    <= prelength_in;
         trigger_type <= trigger_type_in;
         tot          <= tot_in;
         merging      <= merging_in;
         downsample   <= downsample_in;
         trigger_live <= trigger_live_in;
         read_done    <= read_done_in;
         ext_high     <= exttrigin;
         ext_last     <= ext_high;
         lvds_trig    <= lvdsin_trig;
         lvds_trig_b  <= lvdsin_trig_b;
      end
   end

   assign ext_rise = ext_high & ~ext_last;   // first registered high cycle

endmodule

`default_nettype wire

// File: hw/sample_pacer.sv
// write pacing of 2^downsample * merging cycles; a merging of 0 behaves as 1
`default_nettype none
`timescale 1ns/100ps

module sample_pacer (
   input  logic                clklvds,
   input  logic                rst_n,
   input  logic                capturing,
   input  trig_pkg::dsample_t  downsample,
   input  trig_pkg::merge_t    merging,
   output logic                ram_wr,
   output trig_pkg::ram_addr_t ram_wr_address,
   output logic                tick
);
   import trig_pkg::*;

   logic [31:0] ds_cnt;      // runs 1 .. 2^downsample
   merge_t      merge_cnt;   // runs 1 .. merging
   logic        ds_hit;
   logic        merge_hit;

   assign ds_hit    = ds_cnt[downsample];
   assign merge_hit = (merge_cnt >= merging);
   assign tick      = capturing & ds_hit & merge_hit;   // same cycle the counters wrap

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         ds_cnt         <= 32'd1;
         merge_cnt      <= 8'd1;
         ram_wr         <= 1'b0;
         ram_wr_address <= '0;
      end else if (!capturing) begin
         ds_cnt    <= 32'd1;   // restart pacing cleanly on the next capture
         merge_cnt <= 8'd1;
         ram_wr    <= 1'b0;
      end else if (ds_hit) begin
         ds_cnt <= 32'd1;
         if (merge_hit) begin
            merge_cnt      <= 8'd1;
            ram_wr         <= 1'b1;
            ram_wr_address <= ram_wr_address + 1'b1;   // wraps at 1024
         end else begin
            merge_cnt <= merge_cnt + 1'b1;
            ram_wr    <= 1'b0;
         end
      end else begin
         ds_cnt <= ds_cnt + 1'b1;
         ram_wr <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: hw/threshold_detector.sv
// edge trigger compares over all 40 samples, hits valid one cycle after the samples
`default_nettype none
`timescale 1ns/100ps

module threshold_detector (
   input  logic                    clklvds,
   input  logic                    rst_n,
   input  trig_pkg::sample_block_t samples,
   input  trig_pkg::sample_t       lower_thresh,
   input  trig_pkg::sample_t       upper_thresh,
   input  logic                    rising,
   output logic                    arm_hit,
   output logic                    fire_hit
);
   import trig_pkg::*;

   logic [num_samples-1:0] below;   // per-sample compare against lower_thresh
   logic [num_samples-1:0] above;   // per-sample compare against upper_thresh

   always_comb begin
      sample_t s;
      for (int i = 0; i < num_samples; i++) begin
         s        = samples[i*sample_width +: sample_width];
         below[i] = (s < lower_thresh);
         above[i] = (s > upper_thresh);
      end
   end

   // rising waits for a dip below then a rise above, falling the other way round
   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         arm_hit  <= 1'b0;
         fire_hit <= 1'b0;
      end else if (rising) begin
         arm_hit  <= |below;
         fire_hit <= |above;
      end else begin
         arm_hit  <= |above;
         fire_hit <= |below;
      end
   end

endmodule

`default_nettype wire

// File: hw/acq_fsm.sv
// acquisition FSM; holds in st_done until read_done, unknown trigger types fall back to st_ready
`default_nettype none
`timescale 1ns/100ps

module acq_fsm (
   input  logic                  clklvds,
   input  logic                  rst_n,
   input  logic                  tick,
   input  trig_pkg::ram_addr_t   ram_wr_address,
   input  trig_pkg::trig_type_t  trigger_type,
   input  logic                  trigger_live,
   input  logic                  read_done,
   input  trig_pkg::length_t     length,
   input  trig_pkg::length_t     prelength,
   input  trig_pkg::tot_t        tot,
   input  logic                  arm_hit,
   input  logic                  fire_hit,
   input  logic                  ext_high,
   input  logic                  ext_rise,
   input  logic                  lvds_trig,
   input  logic                  lvds_trig_b,
   output logic                  capturing,
   output logic                  rising,
   output trig_pkg::acq_state_t  acq_state,
   output trig_pkg::ram_addr_t   ram_address_triggered,
   output trig_pkg::stamp_t      event_time,
   output trig_pkg::stamp_t      event_count,
   output logic                  lvdsout_trig,
   output logic                  lvdsout_trig_b,
   output logic                  auxout
);
   import trig_pkg::*;

   trig_type_t active_type;   // type latched while in ready
   length_t    sample_cnt;    // write ticks in prefill and post
   tot_t       tot_cnt;
   stamp_t     time_cnt;      // free running event clock
   logic [1:0] pulse_cnt;
   logic       ext_seen;
   logic       ext_armed;
   logic       type_changed;
   logic       echo;
   logic       fire;
   logic       drive_a;
   logic       drive_b;
   ram_addr_t  trig_addr;

   assign capturing    = (acq_state != st_ready) && (acq_state != st_done);
   assign rising       = (active_type == trig_rising);
   assign auxout       = (acq_state == st_post);   // back-panel out for the whole post fill
   assign type_changed = (trigger_type != active_type);
   assign echo         = (active_type == trig_lvds_echo);
   assign ext_armed    = ext_seen | ext_rise;
   assign trig_addr    = ram_wr_address - ram_addr_t'(tot) +
                         ((acq_state == st_wait_ext) ? ram_addr_t'(ext_trig_delay) : ram_addr_t'(0));

   always_comb begin
      fire    = 1'b0;
      drive_a = 1'b1;
      drive_b = 1'b1;
      case (acq_state)
         st_fire:      fire = !type_changed && fire_hit && (tot_cnt >= tot);
         st_wait_lvds: begin
            fire    = !type_changed && (lvds_trig || lvds_trig_b);
            drive_a = lvds_trig || (echo && lvds_trig_b);   // same side always answers
            drive_b = lvds_trig_b || (echo && lvds_trig);
         end
         st_force:     fire = 1'b1;
         st_wait_ext:  fire = !type_changed && ext_armed && ext_high && (tot_cnt >= tot);
         default:      fire = 1'b0;
      endcase
   end

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         acq_state      <= st_ready;
         active_type    <= trig_none;
         sample_cnt     <= '0;
         tot_cnt        <= '0;
         time_cnt       <= '0;
         event_count    <= '0;
         ext_seen       <= 1'b0;
         pulse_cnt      <= '0;
         lvdsout_trig   <= 1'b0;
         lvdsout_trig_b <= 1'b0;
      end else begin
         time_cnt <= time_cnt + 1'b1;

         if (fire) begin
            lvdsout_trig   <= drive_a;
            lvdsout_trig_b <= drive_b;
            pulse_cnt      <= '0;
         end else if (lvdsout_trig || lvdsout_trig_b) begin
            if (pulse_cnt == 2'(lvds_pulse_cycles - 1)) begin
               lvdsout_trig   <= 1'b0;
               lvdsout_trig_b <= 1'b0;
            end else begin
               pulse_cnt <= pulse_cnt + 1'b1;
            end
         end

         case (acq_state)
            st_ready: begin
               active_type <= trigger_type;
               sample_cnt  <= '0;
               tot_cnt     <= '0;
               ext_seen    <= 1'b0;
               if (trigger_type != trig_none && trigger_live) acq_state <= st_prefill;
            end
            st_prefill: begin
               if (type_changed) begin
                  acq_state <= st_ready;
               end else if (sample_cnt < prelength) begin
                  if (tick) sample_cnt <= sample_cnt + 1'b1;
               end else begin
                  sample_cnt <= '0;   // reused for the post fill
                  case (active_type)
                     trig_rising, trig_falling: acq_state <= st_armed;
                     trig_lvds, trig_lvds_echo: acq_state <= st_wait_lvds;
                     trig_auto:                 acq_state <= st_force;
                     trig_ext:                  acq_state <= st_wait_ext;
                     default:                   acq_state <= st_ready;
                  endcase
               end
            end
            st_armed: begin
               if (type_changed) acq_state <= st_ready;
               else if (arm_hit) acq_state <= st_fire;
            end
            st_fire: begin
               if (type_changed) acq_state <= st_ready;
               else if (fire_hit && tick) tot_cnt <= tot_cnt + 1'b1;   // tot in write ticks
            end
            st_wait_lvds: begin
               if (type_changed) acq_state <= st_ready;
            end
            st_force: acq_state <= st_post;
            st_wait_ext: begin
               if (type_changed) begin
                  acq_state <= st_ready;
               end else begin
                  if (ext_rise) ext_seen <= 1'b1;
                  if (ext_armed && ext_high) tot_cnt <= tot_cnt + 1'b1;   // tot in cycles here
                  else tot_cnt <= '0;
               end
            end
            st_post: begin
               if (sample_cnt < length) begin
                  if (tick) sample_cnt <= sample_cnt + 1'b1;
               end else begin
                  event_count <= event_count + 1'b1;
                  acq_state   <= st_done;
               end
            end
            st_done: begin
               sample_cnt <= '0;
               if (read_done) acq_state <= st_ready;
            end
            default: acq_state <= st_ready;
         endcase

         if (fire) acq_state <= st_post;
      end
   end

   // trigger position and time, kept until the next trigger
   always_ff @(posedge clklvds) begin
      if (fire) begin
         ram_address_triggered <= trig_addr;
         event_time            <= time_cnt;
      end
   end

endmodule

`default_nettype wire

// File: hw/triggerer_top.sv
// trigger controller top in the clklvds domain; config inputs are taken through one register stage
`default_nettype none
`timescale 1ns/100ps

module triggerer_top (
   input  logic                    clklvds,
   input  logic                    rst_n,
   input  trig_pkg::sample_block_t samples,
   input  trig_pkg::sample_t       lower_thresh_in,
   input  trig_pkg::sample_t       upper_thresh_in,
   input  trig_pkg::length_t       length_in,
   input  trig_pkg::length_t       prelength_in,
   input  trig_pkg::trig_type_t    trigger_type_in,
   input  trig_pkg::tot_t          tot_in,
   input  trig_pkg::merge_t        merging_in,
   input  trig_pkg::dsample_t      downsample_in,
   input  logic                    trigger_live_in,
   input  logic                    read_done_in,
   input  logic                    exttrigin,
   input  logic                    lvdsin_trig,
   input  logic                    lvdsin_trig_b,
   output logic                    ram_wr,
   output trig_pkg::ram_addr_t     ram_wr_address,
   output trig_pkg::acq_state_t    acq_state,
   output trig_pkg::ram_addr_t     ram_address_triggered,
   output trig_pkg::stamp_t        event_time,
   output trig_pkg::stamp_t        event_count,
   output logic                    lvdsout_trig,
   output logic                    lvdsout_trig_b,
   output logic                    auxout
);
   import trig_pkg::*;

   sample_t    lower_thresh;
   sample_t    upper_thresh;
   length_t    length;
   length_t    prelength;
   trig_type_t trigger_type;
   tot_t       tot;
   merge_t     merging;
   dsample_t   downsample;
   logic       trigger_live;
   logic       read_done;
   logic       ext_high;
   logic       ext_rise;
   logic       lvds_trig;
   logic       lvds_trig_b;
   logic       capturing;
   logic       tick;
   logic       rising;
   logic       arm_hit;
   logic       fire_hit;

   cfg_sync u_cfg_sync (
      .clklvds, .rst_n,
      .lower_thresh_in, .upper_thresh_in, .length_in, .prelength_in,
      .trigger_type_in, .tot_in, .merging_in, .downsample_in,
      .trigger_live_in, .read_done_in, .exttrigin, .lvdsin_trig, .lvdsin_trig_b,
      .lower_thresh, .upper_thresh, .length, .prelength,
      .trigger_type, .tot, .merging, .downsample,
      .trigger_live, .read_done, .ext_high, .ext_rise, .lvds_trig, .lvds_trig_b
   );

   sample_pacer u_sample_pacer (
      .clklvds, .rst_n, .capturing, .downsample, .merging,
      .ram_wr, .ram_wr_address, .tick
   );

   threshold_detector u_threshold_detector (
      .clklvds, .rst_n, .samples, .lower_thresh, .upper_thresh, .rising,
      .arm_hit, .fire_hit
   );

   acq_fsm u_acq_fsm (
      .clklvds, .rst_n, .tick, .ram_wr_address, .trigger_type, .trigger_live,
      .read_done, .length, .prelength, .tot, .arm_hit, .fire_hit,
      .ext_high, .ext_rise, .lvds_trig, .lvds_trig_b,
      .capturing, .rising, .acq_state, .ram_address_triggered, .event_time,
      .event_count, .lvdsout_trig, .lvdsout_trig_b, .auxout
   );

endmodule

`default_nettype wire

// File: testbench/triggerer_assert.sv
// bound into triggerer_top; ram_wr is registered, so it is checked against the state that produced it
`default_nettype none
`timescale 1ns/100ps

module triggerer_assert (
   input logic                 clklvds,
   input logic                 rst_n,
   input logic                 ram_wr,
   input trig_pkg::acq_state_t acq_state,
   input logic                 lvdsout_trig,
   input logic                 lvdsout_trig_b,
   input logic                 auxout
);
   import trig_pkg::*;

   int fail_count = 0;   // summed into the final result

   lvds_a_width: assert property (@(posedge clklvds) disable iff (!rst_n)
      (lvdsout_trig && $past(lvdsout_trig)) |-> !$past(lvdsout_trig, 2))
      else begin
         $error("lvdsout_trig high for more than 2 cycles");
         fail_count = fail_count + 1;
      end

   lvds_b_width: assert property (@(posedge clklvds) disable iff (!rst_n)
      (lvdsout_trig_b && $past(lvdsout_trig_b)) |-> !$past(lvdsout_trig_b, 2))
      else begin
         $error("lvdsout_trig_b high for more than 2 cycles");
         fail_count = fail_count + 1;
      end

   wr_only_capturing: assert property (@(posedge clklvds) disable iff (!rst_n)
      ram_wr |-> ($past(acq_state) != st_ready && $past(acq_state) != st_done))
      else begin
         $error("ram_wr from a cycle in st_ready or st_done");
         fail_count = fail_count + 1;
      end

   // the post fill starts on the same edge as the trigger pulse
   aux_with_trigger: assert property (@(posedge clklvds) disable iff (!rst_n)
      $rose(auxout) |-> $rose(lvdsout_trig || lvdsout_trig_b))
      else begin
         $error("auxout rose without a new LVDS trigger pulse");
         fail_count = fail_count + 1;
      end

endmodule

bind triggerer_top triggerer_assert u_assert (
   .clklvds(clklvds),
   .rst_n(rst_n),
   .ram_wr(ram_wr),
   .acq_state(acq_state),
   .lvdsout_trig(lvdsout_trig),
   .lvdsout_trig_b(lvdsout_trig_b),
   .auxout(auxout)
);

`default_nettype wire

// File: testbench/tb_triggerer.sv
// directed tests of triggerer_top; sample noise stays within +/-128, so only planted samples cross +/-300
`default_nettype none
`timescale 1ns/100ps

module tb_triggerer;
   import trig_pkg::*;

   localparam int cycle_limit = 20000;   // the six tests need about 1000 cycles together

   logic          clklvds;
   logic          rst_n;
   sample_block_t samples;
   sample_t       lower_thresh_in;
   sample_t       upper_thresh_in;
   length_t       length_in;
   length_t       prelength_in;
   trig_type_t    trigger_type_in;
   tot_t          tot_in;
   merge_t        merging_in;
   dsample_t      downsample_in;
   logic          trigger_live_in;
   logic          read_done_in;
   logic          exttrigin;
   logic          lvdsin_trig;
   logic          lvdsin_trig_b;
   logic          ram_wr;
   ram_addr_t     ram_wr_address;
   acq_state_t    acq_state;
   ram_addr_t     ram_address_triggered;
   stamp_t        event_time;
   stamp_t        event_count;
   logic          lvdsout_trig;
   logic          lvdsout_trig_b;
   logic          auxout;

   int            cycles = 0;
   int            errors = 0;
   int            tests_run = 0;
   int            tests_failed = 0;
   logic [31:0]   lfsr = 32'h477e;

   triggerer_top DUT (.*);

   always #50 clklvds = ~clklvds;

   always @(posedge clklvds) cycles <= cycles + 1;

   initial begin
      wait (cycles >= cycle_limit);
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
   end

   // galois form, taps 32 22 2 1
   function automatic logic next_bit();
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      return lfsr[0];
   endfunction

   function automatic sample_block_t noise_block();
      sample_block_t blk;
      logic [7:0]    v;
      blk = '0;
      for (int i = 0; i < num_samples; i++) begin
         for (int j = 0; j < 8; j++) v[j] = next_bit();
         blk[i*sample_width +: sample_width] = {{(sample_width-8){v[7]}}, v};   // -128 .. 127
      end
      return blk;
   endfunction

   // noise on all samples, one of them replaced when idx is not negative
   task automatic drive_block(input int idx, input sample_t val);
      sample_block_t blk;
      blk = noise_block();
      if (idx >= 0) blk[idx*sample_width +: sample_width] = val;
      @(posedge clklvds);
      samples <= blk;
   endtask

   task automatic value_error(input string test, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      $display("error in %s: %s expected %0d, actual %0d", test, what, expected, actual);
      errors++;
   endtask

   task automatic event_error(input string test, input string text);
      $display("%s: %s", test, text);
      errors++;
   endtask

   task automatic finish_test(input string test, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("test %s finished without errors", test);
      end else begin
         tests_failed++;
         $display("test %s finished with %0d errors", test, errors - errors_before);
      end
   endtask

   task automatic configure(input trig_type_t ttype, input dsample_t ds, input merge_t mg,
                            input length_t pre, input length_t len, input tot_t t);
      @(posedge clklvds);
      trigger_type_in <= ttype;
      downsample_in   <= ds;
      merging_in      <= mg;
      prelength_in    <= pre;
      length_in       <= len;
      tot_in          <= t;
      trigger_live_in <= 1'b1;
   endtask

   task automatic wait_state(input acq_state_t st, input int limit, output bit ok);
      int n;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < limit) begin
         @(negedge clklvds);
         n++;
         ok = (acq_state == st);
      end
   endtask

   task automatic wait_ram_wr(input int limit, output bit ok);
      int n;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < limit) begin
         @(negedge clklvds);
         n++;
         ok = ram_wr;
      end
   endtask

   // first lvds output pulse, its width in cycles and the write address of the firing cycle
   task automatic capture_lvds(input int limit, output bit seen, output logic a,
                               output logic b, output int width, output ram_addr_t addr);
      int n;
      n     = 0;
      seen  = 1'b0;
      a     = 1'b0;
      b     = 1'b0;
      width = 0;
      addr  = ram_wr_address;
      while (!seen && n < limit) begin
         @(negedge clklvds);
         n++;
         if (lvdsout_trig || lvdsout_trig_b) begin
            seen = 1'b1;
            a    = lvdsout_trig;
            b    = lvdsout_trig_b;
         end else begin
            addr = ram_wr_address;
         end
      end
      while (seen && (lvdsout_trig || lvdsout_trig_b) && width < 8) begin
         width++;
         @(negedge clklvds);
      end
   endtask

   task automatic pulse_read_done();
      @(posedge clklvds);
      read_done_in <= 1'b1;
      @(posedge clklvds);
      read_done_in <= 1'b0;
   endtask

   // back to st_ready with trig_none from any state, finishing a running event
   task automatic go_idle();
      bit ok;
      @(posedge clklvds);
      trigger_type_in <= trig_none;
      trigger_live_in <= 1'b0;
      read_done_in    <= 1'b1;
      exttrigin       <= 1'b0;
      lvdsin_trig     <= 1'b0;
      lvdsin_trig_b   <= 1'b0;
      wait_state(st_ready, 300, ok);
      if (!ok) event_error("idle", "FSM did not return to st_ready");
      @(posedge clklvds);
      read_done_in <= 1'b0;
   endtask

   task automatic test_idle();
      int e0;
      int out_bad;
      int state_bad;
      e0        = errors;
      out_bad   = 0;
      state_bad = 0;
      configure(trig_none, 5'd1, 8'd1, 16'd4, 16'd4, 8'd0);
      repeat (200) begin
         @(negedge clklvds);
         if (ram_wr || auxout || lvdsout_trig || lvdsout_trig_b) out_bad++;
         if (acq_state != st_ready) state_bad++;
      end
      if (out_bad != 0) event_error("idle", "outputs went high while trig_none was set");
      if (state_bad != 0) event_error("idle", "acq_state left st_ready under trig_none");
      finish_test("idle", e0);
   endtask

   task automatic test_pacing();
      int        e0;
      int        last_cyc;
      ram_addr_t last_addr;
      bit        ok;
      e0 = errors;
      configure(trig_lvds, 5'd2, 8'd3, 16'd40, 16'd4, 8'd0);   // 4 * 3 cycles per write
      wait_ram_wr(100, ok);
      if (!ok) event_error("pacing", "no ram_wr pulse within 100 cycles");
      last_cyc  = cycles;
      last_addr = ram_wr_address;
      for (int i = 0; i < 4 && ok; i++) begin
         wait_ram_wr(30, ok);
         if (!ok) begin
            event_error("pacing", "ram_wr pulses stopped during prefill");
         end else begin
            if (cycles - last_cyc != 12)
               value_error("pacing", "cycles between writes", 12, cycles - last_cyc);
            if (ram_wr_address != ram_addr_t'(last_addr + 10'd1))
               value_error("pacing", "ram_wr_address", last_addr + 10'd1, ram_wr_address);
            last_cyc  = cycles;
            last_addr = ram_wr_address;
         end
      end
      go_idle();
      finish_test("pacing", e0);
   endtask

   task automatic test_auto();
      int        e0;
      stamp_t    ec0;
      stamp_t    t1;
      bit        ok;
      bit        seen;
      logic      a;
      logic      b;
      int        width;
      ram_addr_t addr;
      e0  = errors;
      ec0 = event_count;
      configure(trig_auto, 5'd1, 8'd1, 16'd4, 16'd6, 8'd0);
      capture_lvds(60, seen, a, b, width, addr);
      if (!seen) event_error("auto", "no LVDS pulse after the auto trigger");
      if (a != 1'b1) value_error("auto", "lvdsout_trig", 1, a);
      if (b != 1'b1) value_error("auto", "lvdsout_trig_b", 1, b);
      if (width != 2) value_error("auto", "LVDS pulse width", 2, width);
      if (auxout != 1'b1) value_error("auto", "auxout", 1, auxout);
      wait_state(st_done, 100, ok);
      if (!ok) event_error("auto", "first event never reached st_done");
      if (event_count != ec0 + 1) value_error("auto", "event_count", ec0 + 1, event_count);
      t1 = event_time;
      pulse_read_done();
      wait_state(st_ready, 10, ok);
      if (!ok) event_error("auto", "read_done did not bring the FSM back to st_ready");
      wait_state(st_done, 100, ok);
      if (!ok) event_error("auto", "second event never reached st_done");
      if (event_count != ec0 + 2) value_error("auto", "event_count", ec0 + 2, event_count);
      if (event_time <= t1) event_error("auto", "event_time did not increase between events");
      go_idle();
      finish_test("auto", e0);
   endtask

   task automatic test_rising();
      int        e0;
      bit        quiet;
      bit        seen;
      logic      a;
      logic      b;
      int        width;
      ram_addr_t addr;
      e0    = errors;
      quiet = 1'b1;
      configure(trig_rising, 5'd1, 8'd1, 16'd4, 16'd4, 8'd0);
      repeat (150) begin
         drive_block(-1, '0);
         @(negedge clklvds);
         if (lvdsout_trig || lvdsout_trig_b || auxout) quiet = 1'b0;
      end
      if (!quiet) event_error("rising", "noise inside the thresholds caused a trigger");
      if (acq_state != st_armed) value_error("rising", "acq_state", st_armed, acq_state);
      drive_block(5, -12'sd400);   // dip below lower_thresh arms
      repeat (3) drive_block(-1, '0);
      @(negedge clklvds);
      if (acq_state != st_fire) value_error("rising", "acq_state", st_fire, acq_state);
      drive_block(17, 12'sd400);
      drive_block(-1, '0);
      capture_lvds(20, seen, a, b, width, addr);
      if (!seen) event_error("rising", "a sample above upper_thresh did not trigger");
      if (auxout != 1'b1) value_error("rising", "auxout", 1, auxout);
      if (ram_address_triggered != addr)
         value_error("rising", "ram_address_triggered", addr, ram_address_triggered);
      go_idle();
      finish_test("rising", e0);
   endtask

   task automatic lvds_case(input trig_type_t ttype, input logic from_b,
                            input logic exp_a, input logic exp_b);
      bit        ok;
      bit        seen;
      logic      a;
      logic      b;
      int        width;
      ram_addr_t addr;
      configure(ttype, 5'd1, 8'd1, 16'd4, 16'd4, 8'd0);
      wait_state(st_wait_lvds, 100, ok);
      if (!ok) event_error("lvds", "FSM never reached st_wait_lvds");
      @(posedge clklvds);
      lvdsin_trig   <= !from_b;
      lvdsin_trig_b <= from_b;
      @(posedge clklvds);
      lvdsin_trig   <= 1'b0;
      lvdsin_trig_b <= 1'b0;
      capture_lvds(20, seen, a, b, width, addr);
      if (!seen) event_error("lvds", "no LVDS output after the neighbour trigger");
      if (a != exp_a) value_error("lvds", "lvdsout_trig", exp_a, a);
      if (b != exp_b) value_error("lvds", "lvdsout_trig_b", exp_b, b);
      if (width != 2) value_error("lvds", "LVDS pulse width", 2, width);
      go_idle();
   endtask

   task automatic test_lvds();
      int e0;
      e0 = errors;
      lvds_case(trig_lvds, 1'b0, 1'b1, 1'b0);
      lvds_case(trig_lvds_echo, 1'b1, 1'b1, 1'b1);
      finish_test("lvds", e0);
   endtask

   task automatic test_ext();
      int        e0;
      int        start;
      bit        ok;
      bit        seen;
      logic      a;
      logic      b;
      int        width;
      ram_addr_t addr;
      ram_addr_t exp_addr;
      e0 = errors;
      configure(trig_ext, 5'd1, 8'd1, 16'd4, 16'd4, 8'd8);
      wait_state(st_wait_ext, 100, ok);
      if (!ok) event_error("ext", "FSM never reached st_wait_ext");
      @(posedge clklvds);
      exttrigin <= 1'b1;
      repeat (4) @(posedge clklvds);
      exttrigin <= 1'b0;
      capture_lvds(30, seen, a, b, width, addr);
      if (seen) event_error("ext", "a 4 cycle pulse triggered with tot 8");
      if (acq_state != st_wait_ext) value_error("ext", "acq_state", st_wait_ext, acq_state);
      @(posedge clklvds);
      exttrigin <= 1'b1;
      start = cycles;
      capture_lvds(30, seen, a, b, width, addr);
      if (!seen) event_error("ext", "a 20 cycle pulse did not trigger");
      if (auxout != 1'b1) value_error("ext", "auxout", 1, auxout);
      exp_addr = addr - 10'd8 + 10'd3;   // minus tot, plus the back-panel path delay
      if (ram_address_triggered != exp_addr)
         value_error("ext", "ram_address_triggered", exp_addr, ram_address_triggered);
      while (cycles - start < 20) @(posedge clklvds);
      exttrigin <= 1'b0;
      go_idle();
      finish_test("ext", e0);
   endtask

   initial begin
      clklvds         = 1'b0;
      rst_n           = 1'b0;
      samples         = '0;
      lower_thresh_in = -12'sd300;
      upper_thresh_in = 12'sd300;
      length_in       = '0;
      prelength_in    = '0;
      trigger_type_in = trig_none;
      tot_in          = '0;
      merging_in      = '0;
      downsample_in   = '0;
      trigger_live_in = 1'b0;
      read_done_in    = 1'b0;
      exttrigin       = 1'b0;
      lvdsin_trig     = 1'b0;
      lvdsin_trig_b   = 1'b0;
      repeat (10) @(posedge clklvds);
      rst_n <= 1'b1;
      test_idle();
      test_pacing();
      test_auto();
      test_rising();
      test_lvds();
      test_ext();
      $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, DUT.u_assert.fail_count);
      if (errors == 0 && DUT.u_assert.fail_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
hw/trig_pkg.sv
hw/cfg_sync.sv
hw/sample_pacer.sv
hw/threshold_detector.sv
hw/acq_fsm.sv
hw/triggerer_top.sv
testbench/triggerer_assert.sv
testbench/tb_triggerer.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_triggerer \
   -f project.f -o tb_triggerer

./obj_dir/tb_triggerer +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation ok"
